// ==== Makefile ====
SIM        = verilator
TOP        = dmaControllerTb
RTL_TOP    = dmaController
FILELIST   = dmaController.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
PASS_MSG   = SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== dmaChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dma_params.svh"

module dmaChecker
(
  input  wire                  TCcpuIf,
  input  wire                  rstN,
  input  wire dmaPkg::axiAddrT awaddr,
  input  wire dmaPkg::axiAddrT araddr,
  input  wire dmaPkg::axiDataT wdata,
  input  wire dmaPkg::axiDataT rdata,
  input  wire                  awvalid, awready, wvalid, wready, bvalid, bready,
  input  wire                  arvalid, arready, rvalid, rready,
  input  wire [1:0]            bresp, rresp,
  input  wire dmaPkg::chanVecT dreq, dack,
  input  wire dmaPkg::dmaAddrT addr,
  input  wire                  hlda, hrq, aen, adstb, iorN, iowN, memrN, memwN, eopN,
  output int                   errCount,
  output int                   xferCount
);

  dmaPkg::dmaAddrT baseA [`DMA_CHANNELS];
  dmaPkg::dmaAddrT curA [`DMA_CHANNELS];
  dmaPkg::dmaCountT baseC [`DMA_CHANNELS];
  dmaPkg::dmaCountT curC [`DMA_CHANNELS];
  logic [3:0] modeR [`DMA_CHANNELS];   // Auto, dec, type
  logic [1:0] cmdR;
  dmaPkg::chanVecT maskR, statR, pend;
  dmaPkg::chanIdxT ch, lastCh;
  int phase;   // 0 idle, 1 hold wait, 2 S1, 3 S2, 4 S4
  logic [33:0] rdQ [$];
  logic [1:0] bQ [$];
  logic [33:0] rdExp;
  logic ioRdMemWr, ioWrMemRd;
  logic wrFree, rdFree;
  int errs = 0;
  int xfers = 0;

  assign errCount = errs;
  assign xferCount = xfers;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      errs++;
      $display("ERR %s expected %h actual %h at %0t ns", name, exp, act, $time);
    end
  endtask

  function automatic dmaPkg::chanIdxT pickWinner(dmaPkg::chanVecT req);
    dmaPkg::chanIdxT c;
    for (int i = 1; i <= `DMA_CHANNELS; i++)
    begin
      c = cmdR[`DMA_CMD_ROTATE] ? lastCh + dmaPkg::chanIdxT'(i) : dmaPkg::chanIdxT'(i - 1);
      if (req[c])
        return c;
    end
    return lastCh;
  endfunction

  ////////////////////////////////////////////////////////////
  // Register map model

  function automatic logic [33:0] readModel(dmaPkg::axiAddrT a);
    dmaPkg::chanIdxT c;
    c = a[5:4];
    if (a < `DMA_REG_COMMAND)
    begin
      case (a[3:2])
        2'd0: return {`AXI_RESP_OKAY, 16'h0, baseA[c]};
        2'd1: return {`AXI_RESP_OKAY, 16'h0, baseC[c]};
        2'd2: return {`AXI_RESP_OKAY, 28'h0, modeR[c]};
        default: return {`AXI_RESP_OKAY, curC[c], curA[c]};
      endcase
    end
    case ({a[7:2], 2'b00})
      `DMA_REG_COMMAND: return {`AXI_RESP_OKAY, 30'h0, cmdR};
      `DMA_REG_MASK: return {`AXI_RESP_OKAY, 28'h0, maskR};
      `DMA_REG_STATUS: return {`AXI_RESP_OKAY, 28'h0, statR};
      default: return {`AXI_RESP_SLVERR, 32'h0};
    endcase
  endfunction

  function automatic logic [1:0] writeModel(dmaPkg::axiAddrT a, dmaPkg::axiDataT d);
    dmaPkg::chanIdxT c;
    c = a[5:4];
    if (a < `DMA_REG_COMMAND)
    begin
      case (a[3:2])
        2'd0:
        begin
          baseA[c] = d[`DMA_ADDR_W-1:0];
          curA[c] = d[`DMA_ADDR_W-1:0];
        end
        2'd1:
        begin
          baseC[c] = d[`DMA_COUNT_W-1:0];
          curC[c] = d[`DMA_COUNT_W-1:0];
        end
        2'd2: modeR[c] = d[3:0];
        default: return `AXI_RESP_SLVERR;   // Current is read only
      endcase
    end
    else if ({a[7:2], 2'b00} == `DMA_REG_COMMAND)
      cmdR = d[1:0];
    else if ({a[7:2], 2'b00} == `DMA_REG_MASK)
      maskR = d[`DMA_CHANNELS-1:0];
    else
      return `AXI_RESP_SLVERR;
    return `AXI_RESP_OKAY;
  endfunction

  task automatic finishXfer();
    logic tc;
    tc = curC[ch] == '0;
    if (tc && modeR[ch][`DMA_MODE_AUTO])
    begin
      curA[ch] = baseA[ch];   // Reload
      curC[ch] = baseC[ch];
    end
    else
    begin
      curA[ch] = modeR[ch][`DMA_MODE_DEC] ? curA[ch] - 1'b1 : curA[ch] + 1'b1;
      curC[ch] = curC[ch] - 1'b1;
    end
    if (tc)
    begin
      statR[ch] = 1'b1;
      if (!modeR[ch][`DMA_MODE_AUTO])
        maskR[ch] = 1'b1;
    end
    xfers++;
  endtask

  ////////////////////////////////////////////////////////////
  // Compare at the falling edge and step the model

  always @(negedge TCcpuIf)
  begin
    if (!rstN)
    begin
      phase = 0;
      cmdR = '0;
      maskR = '1;
      statR = '0;
      ch = '0;
      lastCh = dmaPkg::chanIdxT'(`DMA_CHANNELS - 1);   // Channel 0 leads after reset
      for (int c = 0; c < `DMA_CHANNELS; c++)
        modeR[c] = '0;
      rdQ.delete();
      bQ.delete();
    end
    else
    begin
      ioRdMemWr = phase == 3 && modeR[ch][1:0] == dmaPkg::xferWrite;
      ioWrMemRd = phase == 3 && modeR[ch][1:0] == dmaPkg::xferRead;
      compare("hrq", phase != 0, hrq);
      compare("aen", phase >= 2, aen);
      compare("adstb", phase == 2, adstb);
      compare("dack", (phase == 2 || phase == 3) ? 32'h1 << ch : 32'h0, dack);
      compare("iorN", !ioRdMemWr, iorN);
      compare("memwN", !ioRdMemWr, memwN);
      compare("iowN", !ioWrMemRd, iowN);
      compare("memrN", !ioWrMemRd, memrN);
      compare("eopN", !(phase == 4 && curC[ch] == '0), eopN);
      if (phase >= 2)
        compare("addr", curA[ch], addr);

      // Accepts only with no response outstanding
      wrFree = awvalid && wvalid && bQ.size() == 0;
      rdFree = arvalid && rdQ.size() == 0;
      compare("awready", wrFree, awready);
      compare("wready", wrFree, wready);
      compare("arready", rdFree, arready);

      if (bvalid && bready)
      begin
        if (bQ.size() == 0)
        begin
          errs++;
          $display("Write response seen with no write accepted at %0t ns", $time);
        end
        else
          compare("bresp", bQ.pop_front(), bresp);
      end
      if (rvalid && rready)
      begin
        if (rdQ.size() == 0)
        begin
          errs++;
          $display("Read response seen with no read accepted at %0t ns", $time);
        end
        else
        begin
          rdExp = rdQ.pop_front();
          compare("rresp", rdExp[33:32], rresp);
          if (rdExp[33:32] == `AXI_RESP_OKAY)
            compare("rdata", rdExp[31:0], rdata);
        end
      end

      if (arvalid && arready)
      begin
        rdQ.push_back(readModel(araddr));
        if ({araddr[7:2], 2'b00} == `DMA_REG_STATUS)
          statR = '0;   // Clear on read
      end

      pend = cmdR[`DMA_CMD_ENABLE] ? dreq & ~maskR : '0;
      case (phase)
        0:
        begin
          if (pend != '0)
          begin
            ch = pickWinner(pend);
            lastCh = ch;
            phase = 1;
          end
        end
        1: phase = hlda ? 2 : 1;
        4:
        begin
          finishXfer();
          phase = 0;
        end
        default: phase++;
      endcase

      // CPU write lands after the TC update, so its mask wins
      if (awvalid && awready)
        bQ.push_back(writeModel(awaddr, wdata));
    end
  end

endmodule

`default_nettype wire

// ==== dmaController.f ====
+incdir+.
dmaPkg.sv
dmaRegIf.sv
dmaRegisters.sv
priorityLogic.sv
timingAndControl.sv
dmaController.sv
dmaChecker.sv
dmaControllerTb.sv

// ==== dmaController.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dma_params.svh"

module dmaController
(
  input  wire                     TCcpuIf,
  input  wire                     rstN,
  // AXI4-Lite slave
  input  wire dmaPkg::axiAddrT    awaddr,
  input  wire                     awvalid,
  output logic                    awready,
  input  wire dmaPkg::axiDataT    wdata,
  input  wire [`AXI_DATA_W/8-1:0] wstrb,
  input  wire                     wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  wire                     bready,
  input  wire dmaPkg::axiAddrT    araddr,
  input  wire                     arvalid,
  output logic                    arready,
  output dmaPkg::axiDataT         rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  wire                     rready,
  // Device and hold side
  input  wire dmaPkg::chanVecT    dreq,
  input  wire                     hlda,
  output logic                    hrq,
  output dmaPkg::chanVecT         dack,
  output logic                    aen,
  output logic                    adstb,
  output dmaPkg::dmaAddrT         addr,
  output logic                    iorN,
  output logic                    iowN,
  output logic                    memrN,
  output logic                    memwN,
  output logic                    eopN
);

  logic latchGrant;
  logic anyRequest;
  logic assertDack;

  dmaRegIf regIf ();

  dmaRegisters regs_i
  (
    .TCcpuIf, .rstN,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .regIf(regIf.registers)
  );

  priorityLogic prio_i
  (
    .TCcpuIf, .rstN, .dreq, .latchGrant, .assertDack,
    .anyRequest, .dack,
    .regIf(regIf.prio)
  );

  timingAndControl tc_i
  (
    .TCcpuIf, .rstN, .anyRequest, .hlda,
    .latchGrant, .assertDack,
    .hrq, .aen, .adstb, .addr,
    .iorN, .iowN, .memrN, .memwN, .eopN,
    .regIf(regIf.timing)
  );

endmodule

`default_nettype wire

// ==== dmaControllerTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dma_params.svh"

module dmaControllerTb;

  logic TCcpuIf = 1'b0;
  logic rstN;
  dmaPkg::axiAddrT awaddr, araddr;
  dmaPkg::axiDataT wdata, rdata;
  logic [`AXI_DATA_W/8-1:0] wstrb;
  logic awvalid, wvalid, arvalid;
  logic bready = 1'b0;
  logic rready = 1'b0;
  logic awready, wready, bvalid, arready, rvalid;
  logic [1:0] bresp, rresp;
  dmaPkg::chanVecT dreq = '0;
  dmaPkg::chanVecT dack, devWant;
  logic hlda = 1'b0;
  logic hrq, aen, adstb, iorN, iowN, memrN, memwN, eopN;
  dmaPkg::dmaAddrT addr;

  logic [31:0] lfsr = 32'h48538697;
  int holdWait = 0;
  int cycles = 0;
  int xferBudget = 0;
  int testErrs = 0;
  int errCount, xferCount;

  dmaController dut_i (.*);

  dmaChecker chk_i (.*);

  always #10 TCcpuIf = !TCcpuIf;

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic dmaPkg::axiAddrT chanReg(int c, dmaPkg::axiAddrT off);
    return dmaPkg::axiAddrT'(c) * `DMA_CHAN_STRIDE + off;
  endfunction

  ////////////////////////////////////////////////////////////
  // Device, HLDA and ready models

  always @(posedge TCcpuIf)
  begin : deviceModel
    dmaPkg::chanVecT want;
    want = devWant;
    #2;
    dreq = want & ~dack;   // Held until acknowledged
    if (!hrq)
    begin
      hlda = 1'b0;
      holdWait = int'(randBits(2));
    end
    else if (holdWait == 0)
      hlda = 1'b1;
    else
      holdWait--;
    bready = randBits(2) != 0;
    rready = randBits(2) != 0;
  end

  always @(posedge TCcpuIf)
  begin
    cycles++;
    if (cycles > xferBudget * 8 + 2000)
    begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // AXI driver tasks start just after a rising edge

  task automatic axiWrite(input dmaPkg::axiAddrT a, input dmaPkg::axiDataT d);
    awaddr = a;
    wdata = d;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge TCcpuIf);
    while (!awready)
      @(negedge TCcpuIf);
    @(posedge TCcpuIf);
    #2;
    awvalid = 1'b0;
    wvalid = 1'b0;
    @(negedge TCcpuIf);
    while (!(bvalid && bready))
      @(negedge TCcpuIf);
    @(posedge TCcpuIf);
    #2;
  endtask

  task automatic axiRead(input dmaPkg::axiAddrT a);
    araddr = a;
    arvalid = 1'b1;
    @(negedge TCcpuIf);
    while (!arready)
      @(negedge TCcpuIf);
    @(posedge TCcpuIf);
    #2;
    arvalid = 1'b0;
    @(negedge TCcpuIf);
    while (!(rvalid && rready))
      @(negedge TCcpuIf);
    @(posedge TCcpuIf);
    #2;
  endtask

  task automatic setupChannel(input int c, input logic [3:0] mode, input dmaPkg::dmaCountT cnt);
    axiWrite(chanReg(c, `DMA_REG_BASE_ADDR), randBits(16));
    axiWrite(chanReg(c, `DMA_REG_BASE_COUNT), 32'(cnt));
    axiWrite(chanReg(c, `DMA_REG_MODE), 32'(mode));
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge TCcpuIf);
    #2;
  endtask

  task automatic waitEop();
    @(negedge TCcpuIf);
    while (eopN)
      @(negedge TCcpuIf);
    @(posedge TCcpuIf);
    #2;
  endtask

  // Devices go quiet and the bus returns to idle
  task automatic settle();
    devWant = '0;
    repeat (3) @(negedge TCcpuIf);
    while (hrq)
      @(negedge TCcpuIf);
    @(posedge TCcpuIf);
    #2;
  endtask

  task automatic finishTest(input string name);
    $display("%-16s %s, %0d errors", name, (errCount == testErrs) ? "ok" : "failed",
             errCount - testErrs);
    testErrs = errCount;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    int ch;
    dmaPkg::dmaCountT cnt;
    rstN = 1'b0;
    awaddr = '0;
    araddr = '0;
    wdata = '0;
    wstrb = '1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    arvalid = 1'b0;
    devWant = '0;
    waitCycles(10);
    rstN = 1'b1;
    waitCycles(2);

    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      setupChannel(i, 4'(randBits(4)), 16'(randBits(16)));
      axiRead(chanReg(i, `DMA_REG_CURRENT));
      axiRead(chanReg(i, `DMA_REG_MODE));
    end
    axiWrite(8'h50, randBits(32));   // Unmapped
    axiWrite(chanReg(1, `DMA_REG_CURRENT), randBits(32));
    axiWrite(`DMA_REG_STATUS, randBits(32));
    axiRead(8'h50);
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      axiRead(chanReg(i, `DMA_REG_CURRENT));
      axiRead(chanReg(i, `DMA_REG_BASE_ADDR));
      axiRead(chanReg(i, `DMA_REG_BASE_COUNT));
    end
    finishTest("registers");

    axiWrite(`DMA_REG_COMMAND, 32'h1);
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      cnt = 16'(randBits(3));
      xferBudget += int'(cnt) + 1;
      setupChannel(i, 4'(randBits(3)), cnt);
      axiWrite(`DMA_REG_MASK, ~(32'h1 << i));
      devWant = dmaPkg::chanVecT'(1) << i;
      waitEop();
      waitCycles(20);   // Channel masked so no more transfers
      settle();
      axiRead(`DMA_REG_STATUS);
      axiRead(`DMA_REG_STATUS);
      axiRead(`DMA_REG_MASK);
    end
    finishTest("single channel");

    ch = int'(randBits(2));
    xferBudget += 8;
    setupChannel(ch, 4'(8 | randBits(3)), 16'd1);
    axiWrite(`DMA_REG_MASK, ~(32'h1 << ch));
    devWant = dmaPkg::chanVecT'(1) << ch;
    waitEop();
    waitEop();
    settle();
    axiRead(`DMA_REG_STATUS);
    axiRead(`DMA_REG_STATUS);
    axiRead(chanReg(ch, `DMA_REG_CURRENT));
    axiWrite(`DMA_REG_MASK, 32'hF);
    finishTest("terminal count");

    for (int rot = 0; rot < 2; rot++)
    begin
      axiWrite(`DMA_REG_COMMAND, 32'h1 | (rot << 1));
      for (int i = 0; i < `DMA_CHANNELS; i++)
        setupChannel(i, 4'(randBits(3)), 16'h00FF);
      axiWrite(`DMA_REG_MASK, 32'h0);
      xferBudget += 40;
      repeat (25)
      begin
        devWant = dmaPkg::chanVecT'(randBits(4));
        waitCycles(8);
      end
      settle();
      axiWrite(`DMA_REG_MASK, 32'hF);
    end
    finishTest("priority");

    axiWrite(`DMA_REG_COMMAND, 32'h0);
    setupChannel(0, 4'(randBits(3)), 16'd2);
    axiWrite(`DMA_REG_MASK, 32'hE);
    devWant = 4'h1;
    waitCycles(30);   // Controller disabled
    axiWrite(`DMA_REG_MASK, 32'hF);
    axiWrite(`DMA_REG_COMMAND, 32'h1);
    waitCycles(30);   // Channel masked
    xferBudget += 3;
    axiWrite(`DMA_REG_MASK, 32'hE);
    waitEop();
    settle();
    finishTest("mask and enable");

    $display("Done: %0d transfers checked, %0d errors", xferCount, errCount);
    if (errCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dmaPkg.sv ====
`default_nettype none

`include "dma_params.svh"

package dmaPkg;

  ////////////////////////////////////////////////////////////
  // Datapath widths

  typedef logic [`DMA_ADDR_W-1:0] dmaAddrT;
  typedef logic [`DMA_COUNT_W-1:0] dmaCountT;  // N means N+1 transfers

  typedef logic [$clog2(`DMA_CHANNELS)-1:0] chanIdxT;
  typedef logic [`DMA_CHANNELS-1:0] chanVecT;

  typedef logic [`AXI_ADDR_W-1:0] axiAddrT;
  typedef logic [`AXI_DATA_W-1:0] axiDataT;

  ////////////////////////////////////////////////////////////
  // Transfer type

  typedef logic [1:0] xferTypeT;   // 11 acts as verify

  localparam xferTypeT xferVerify = 2'b00;
  localparam xferTypeT xferWrite  = 2'b01;  // IOR + MEMW
  localparam xferTypeT xferRead   = 2'b10;  // IOW + MEMR

  ////////////////////////////////////////////////////////////
  // Bus cycle states

  typedef enum logic [4:0]
  {
    SI = 5'b00001,  // Idle
    S0 = 5'b00010,  // Waiting for HLDA
    S1 = 5'b00100,
    S2 = 5'b01000,
    S4 = 5'b10000
  } busStateT;

endpackage

`default_nettype wire

// ==== dmaRegIf.sv ====
`timescale 1ns/1ns
`default_nettype none

interface dmaRegIf;

  dmaPkg::chanIdxT activeChannel;   // Latched winner
  dmaPkg::chanVecT reqEnable;       // Unmasked and enabled
  logic rotatingPriority;

  // Values of the active channel
  dmaPkg::dmaAddrT activeAddr;
  dmaPkg::xferTypeT activeXferType;
  logic activeCountZero;

  logic updateCurrent;   // One cycle in S4

  modport registers
  (
    input  activeChannel,
    input  updateCurrent,
    output reqEnable,
    output rotatingPriority,
    output activeAddr,
    output activeXferType,
    output activeCountZero
  );

  modport prio
  (
    input  reqEnable,
    input  rotatingPriority,
    output activeChannel
  );

  modport timing
  (
    input  activeAddr,
    input  activeXferType,
    input  activeCountZero,
    output updateCurrent
  );

endinterface

`default_nettype wire

// ==== dmaRegisters.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dma_params.svh"

module dmaRegisters
(
  input  wire                        TCcpuIf,
  input  wire                        rstN,
  input  wire dmaPkg::axiAddrT       awaddr,
  input  wire                        awvalid,
  output logic                       awready,
  input  wire dmaPkg::axiDataT       wdata,
  input  wire [`AXI_DATA_W/8-1:0]    wstrb,
  input  wire                        wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  wire                        bready,
  input  wire dmaPkg::axiAddrT       araddr,
  input  wire                        arvalid,
  output logic                       arready,
  output dmaPkg::axiDataT            rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  wire                        rready,
  dmaRegIf.registers                 regIf
);

  dmaPkg::dmaAddrT baseAddr [`DMA_CHANNELS];
  dmaPkg::dmaAddrT curAddr [`DMA_CHANNELS];
  dmaPkg::dmaCountT baseCount [`DMA_CHANNELS];
  dmaPkg::dmaCountT curCount [`DMA_CHANNELS];
  dmaPkg::xferTypeT modeType [`DMA_CHANNELS];
  logic modeDec [`DMA_CHANNELS];
  logic modeAuto [`DMA_CHANNELS];

  logic [1:0] command;
  dmaPkg::chanVecT mask;
  dmaPkg::chanVecT status;
  dmaPkg::chanVecT tcSet;
  dmaPkg::chanIdxT actCh;

  logic wrAccept, rdAccept;
  logic wrInChan, rdInChan;
  dmaPkg::chanIdxT wrChan, rdChan;
  dmaPkg::axiAddrT wrOff, rdOff, wrWord, rdWord;
  logic wrSelBase, wrSelCount, wrSelMode, wrSelCmd, wrSelMask, wrOk;
  logic rdOk, rdStatus;
  dmaPkg::axiDataT wrOld, wrData, rdValue;

  function automatic dmaPkg::axiDataT applyStrb(dmaPkg::axiDataT oldVal,
                                                dmaPkg::axiDataT newVal,
                                                logic [`AXI_DATA_W/8-1:0] strb);
    dmaPkg::axiDataT result;
    result = oldVal;
    for (int b = 0; b < `AXI_DATA_W/8; b++)
    begin
      if (strb[b])
        result[8*b +: 8] = newVal[8*b +: 8];
    end
    return result;
  endfunction

  function automatic dmaPkg::axiDataT modeWord(dmaPkg::chanIdxT ch);
    dmaPkg::axiDataT word;
    word = '0;
    word[1:0] = modeType[ch];
    word[`DMA_MODE_DEC] = modeDec[ch];
    word[`DMA_MODE_AUTO] = modeAuto[ch];
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // Handshakes and decode

  assign wrAccept = awvalid && wvalid && !bvalid;
  assign awready  = wrAccept;
  assign wready   = wrAccept;
  assign rdAccept = arvalid && !rvalid;
  assign arready  = rdAccept;

  assign wrInChan = awaddr < `DMA_CHANNELS * `DMA_CHAN_STRIDE;
  assign rdInChan = araddr < `DMA_CHANNELS * `DMA_CHAN_STRIDE;
  assign wrChan = awaddr[5:4];
  assign rdChan = araddr[5:4];
  assign wrOff  = {4'h0, awaddr[3:2], 2'b00};
  assign rdOff  = {4'h0, araddr[3:2], 2'b00};
  assign wrWord = {awaddr[7:2], 2'b00};
  assign rdWord = {araddr[7:2], 2'b00};

  always_comb
  begin
    {wrSelBase, wrSelCount, wrSelMode, wrSelCmd, wrSelMask} = '0;
    wrOld = '0;
    if (wrInChan)
    begin
      case (wrOff)
        `DMA_REG_BASE_ADDR:
        begin
          wrSelBase = 1'b1;
          wrOld = dmaPkg::axiDataT'(baseAddr[wrChan]);
        end
        `DMA_REG_BASE_COUNT:
        begin
          wrSelCount = 1'b1;
          wrOld = dmaPkg::axiDataT'(baseCount[wrChan]);
        end
        `DMA_REG_MODE:
        begin
          wrSelMode = 1'b1;
          wrOld = modeWord(wrChan);
        end
        default: ;  // Current is read only
      endcase
    end
    else if (wrWord == `DMA_REG_COMMAND)
    begin
      wrSelCmd = 1'b1;
      wrOld = dmaPkg::axiDataT'(command);
    end
    else if (wrWord == `DMA_REG_MASK)
    begin
      wrSelMask = 1'b1;
      wrOld = dmaPkg::axiDataT'(mask);
    end
  end

  assign wrOk = wrSelBase || wrSelCount || wrSelMode || wrSelCmd || wrSelMask;
  assign wrData = applyStrb(wrOld, wdata, wstrb);

  always_comb
  begin
    rdValue = '0;
    rdOk = 1'b1;
    if (rdInChan)
    begin
      case (rdOff)
        `DMA_REG_BASE_ADDR:  rdValue = dmaPkg::axiDataT'(baseAddr[rdChan]);
        `DMA_REG_BASE_COUNT: rdValue = dmaPkg::axiDataT'(baseCount[rdChan]);
        `DMA_REG_MODE:       rdValue = modeWord(rdChan);
        default:             rdValue = {curCount[rdChan], curAddr[rdChan]};
      endcase
    end
    else
    begin
      case (rdWord)
        `DMA_REG_COMMAND: rdValue = dmaPkg::axiDataT'(command);
        `DMA_REG_MASK:    rdValue = dmaPkg::axiDataT'(mask);
        `DMA_REG_STATUS:  rdValue = dmaPkg::axiDataT'(status);
        default:          rdOk = 1'b0;
      endcase
    end
  end

  assign rdStatus = !rdInChan && rdWord == `DMA_REG_STATUS;

  ////////////////////////////////////////////////////////////
  // Active channel view

  assign actCh = regIf.activeChannel;
  assign regIf.reqEnable = command[`DMA_CMD_ENABLE] ? ~mask : '0;
  assign regIf.rotatingPriority = command[`DMA_CMD_ROTATE];
  assign regIf.activeAddr = curAddr[actCh];
  assign regIf.activeXferType = modeType[actCh];
  assign regIf.activeCountZero = curCount[actCh] == '0;

  assign tcSet = (regIf.updateCurrent && regIf.activeCountZero) ?
                 dmaPkg::chanVecT'(1) << actCh : '0;

  always_ff @(posedge TCcpuIf or negedge rstN)
  begin
    if (!rstN)
    begin
      command <= '0;
      mask    <= '1;   // All channels masked
      status  <= '0;
      bvalid  <= 1'b0;
      bresp   <= `AXI_RESP_OKAY;
      rvalid  <= 1'b0;
      rresp   <= `AXI_RESP_OKAY;
      for (int c = 0; c < `DMA_CHANNELS; c++)
      begin
        modeType[c] <= dmaPkg::xferVerify;
        modeDec[c]  <= 1'b0;
        modeAuto[c] <= 1'b0;
      end
    end
    else
    begin
      if (rdAccept && rdStatus)
        status <= tcSet;   // Clear on read
      else
        status <= status | tcSet;
      if (tcSet != '0 && !modeAuto[actCh])
        mask <= mask | tcSet;
      if (wrAccept && wrSelMode)
      begin
        modeType[wrChan] <= wrData[1:0];
        modeDec[wrChan]  <= wrData[`DMA_MODE_DEC];
        modeAuto[wrChan] <= wrData[`DMA_MODE_AUTO];
      end
      if (wrAccept && wrSelCmd)
        command <= wrData[1:0];
      if (wrAccept && wrSelMask)
        mask <= wrData[`DMA_CHANNELS-1:0];   // CPU wins over TC
      if (wrAccept)
      begin
        bvalid <= 1'b1;
        bresp  <= wrOk ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
      end
      else if (bready)
        bvalid <= 1'b0;
      if (rdAccept)
      begin
        rvalid <= 1'b1;
        rresp  <= rdOk ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
      end
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge TCcpuIf)
  begin
    if (regIf.updateCurrent)
    begin
      if (regIf.activeCountZero && modeAuto[actCh])
      begin
        curAddr[actCh]  <= baseAddr[actCh];
        curCount[actCh] <= baseCount[actCh];
      end
      else
      begin
        curAddr[actCh]  <= modeDec[actCh] ? curAddr[actCh] - 1'b1 : curAddr[actCh] + 1'b1;
        curCount[actCh] <= curCount[actCh] - 1'b1;
      end
    end
    if (wrAccept && wrSelBase)
    begin
      baseAddr[wrChan] <= wrData[`DMA_ADDR_W-1:0];
      curAddr[wrChan]  <= wrData[`DMA_ADDR_W-1:0];
    end
    if (wrAccept && wrSelCount)
    begin
      baseCount[wrChan] <= wrData[`DMA_COUNT_W-1:0];
      curCount[wrChan]  <= wrData[`DMA_COUNT_W-1:0];
    end
    if (rdAccept)
      rdata <= rdValue;
  end

  bvalidHold: assert property (@(posedge TCcpuIf) disable iff (!rstN)
    bvalid && !bready |=> bvalid);

  // Timing must never run a cycle for a masked channel
  noMaskedUpdate: assert property (@(posedge TCcpuIf) disable iff (!rstN)
    regIf.updateCurrent |-> !mask[actCh]);

endmodule

`default_nettype wire

// ==== dma_params.svh ====
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Controller geometry
`define DMA_CHANNELS 4
`define DMA_ADDR_W   16
`define DMA_COUNT_W  16

// AXI4-Lite slave
`define AXI_ADDR_W 8
`define AXI_DATA_W 32
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

// Channel n block starts at n * stride
`define DMA_CHAN_STRIDE    8'h10
`define DMA_REG_BASE_ADDR  8'h00
`define DMA_REG_BASE_COUNT 8'h04
`define DMA_REG_MODE       8'h08
`define DMA_REG_CURRENT    8'h0C  // Count high, address low

// Global registers
`define DMA_REG_COMMAND 8'h40
`define DMA_REG_MASK    8'h44
`define DMA_REG_STATUS  8'h48

// Field positions
`define DMA_CMD_ENABLE 0
`define DMA_CMD_ROTATE 1
`define DMA_MODE_DEC   2   // Bits 1:0 hold the transfer type
`define DMA_MODE_AUTO  3

`endif

// ==== priorityLogic.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dma_params.svh"

module priorityLogic
(
  input  wire                  TCcpuIf,
  input  wire                  rstN,
  input  wire dmaPkg::chanVecT dreq,
  input  wire                  latchGrant,
  input  wire                  assertDack,
  output logic                 anyRequest,
  output dmaPkg::chanVecT      dack,
  dmaRegIf.prio                regIf
);

  dmaPkg::chanVecT pending;
  dmaPkg::chanIdxT winner;
  dmaPkg::chanIdxT cand;

  assign pending = dreq & regIf.reqEnable;
  assign anyRequest = |pending;

  ////////////////////////////////////////////////////////////
  // Winner select

  always_comb
  begin
    winner = regIf.activeChannel;
    cand = '0;
    if (regIf.rotatingPriority)
    begin
      // Walk backwards so the nearest channel after the last one wins
      for (int i = `DMA_CHANNELS; i >= 1; i--)
      begin
        cand = regIf.activeChannel + dmaPkg::chanIdxT'(i);
        if (pending[cand])
          winner = cand;
      end
    end
    else
    begin
      for (int i = `DMA_CHANNELS - 1; i >= 0; i--)
      begin
        if (pending[i])
          winner = dmaPkg::chanIdxT'(i);   // Lowest wins
      end
    end
  end

  // Also the last serviced channel for rotation
  always_ff @(posedge TCcpuIf or negedge rstN)
  begin
    if (!rstN)
      regIf.activeChannel <= dmaPkg::chanIdxT'(`DMA_CHANNELS - 1);
    else if (latchGrant)
      regIf.activeChannel <= winner;
  end

  assign dack = assertDack ? dmaPkg::chanVecT'(1) << regIf.activeChannel : '0;

  dackOneHot: assert property (@(posedge TCcpuIf) disable iff (!rstN)
    $onehot0(dack));

endmodule

`default_nettype wire

// ==== timingAndControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module timingAndControl
(
  input  wire             TCcpuIf,
  input  wire             rstN,
  input  wire             anyRequest,
  input  wire             hlda,
  output logic            latchGrant,
  output logic            assertDack,
  output logic            hrq,
  output logic            aen,
  output logic            adstb,
  output dmaPkg::dmaAddrT addr,
  output logic            iorN,
  output logic            iowN,
  output logic            memrN,
  output logic            memwN,
  output logic            eopN,
  dmaRegIf.timing         regIf
);

  dmaPkg::busStateT state, nextState;
  logic busOwned;
  logic ioRdMemWr;
  logic ioWrMemRd;

  ////////////////////////////////////////////////////////////
  // Bus cycle FSM

  always_ff @(posedge TCcpuIf or negedge rstN)
  begin
    if (!rstN)
      state <= dmaPkg::SI;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    latchGrant = 1'b0;
    case (state)
      dmaPkg::SI:
      begin
        if (anyRequest)
        begin
          latchGrant = 1'b1;
          nextState = dmaPkg::S0;
        end
      end
      dmaPkg::S0:
      begin
        if (hlda)   // Hold until the CPU releases the bus
          nextState = dmaPkg::S1;
      end
      dmaPkg::S1: nextState = dmaPkg::S2;
      dmaPkg::S2: nextState = dmaPkg::S4;
      dmaPkg::S4: nextState = dmaPkg::SI;
      default:    nextState = dmaPkg::SI;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Bus outputs

  assign busOwned = state inside {dmaPkg::S1, dmaPkg::S2, dmaPkg::S4};

  assign hrq = state != dmaPkg::SI;
  assign aen = busOwned;
  assign adstb = state == dmaPkg::S1;
  assign assertDack = state inside {dmaPkg::S1, dmaPkg::S2};
  assign addr = busOwned ? regIf.activeAddr : '0;

  // Strobe pairs only in S2
  assign ioRdMemWr = state == dmaPkg::S2 && regIf.activeXferType == dmaPkg::xferWrite;
  assign ioWrMemRd = state == dmaPkg::S2 && regIf.activeXferType == dmaPkg::xferRead;

  assign iorN  = !ioRdMemWr;
  assign memwN = !ioRdMemWr;
  assign iowN  = !ioWrMemRd;
  assign memrN = !ioWrMemRd;

  assign regIf.updateCurrent = state == dmaPkg::S4;
  assign eopN = !(state == dmaPkg::S4 && regIf.activeCountZero);   // Terminal count

  stateOneHot: assert property (@(posedge TCcpuIf) disable iff (!rstN)
    $onehot(state));

  memStrobeExcl: assert property (@(posedge TCcpuIf) disable iff (!rstN)
    !(!memrN && !memwN));

endmodule

`default_nettype wire
